//--- Bender.yml
package:
  name: stereo_front

sources:
  - src/stereo_pkg.sv
  - src/stereo_regs_pkg.sv
  - src/apb_cfg_regs.sv
  - src/input_align.sv
  - src/right_delay_line.sv
  - src/match_cost_unit.sv
  - src/disparity_select.sv
  - src/stereo_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/tb_stereo.sv

//--- flist.f
src/stereo_pkg.sv
src/stereo_regs_pkg.sv
src/apb_cfg_regs.sv
src/input_align.sv
src/right_delay_line.sv
src/match_cost_unit.sv
src/disparity_select.sv
src/stereo_top.sv
tb/tb_clock.sv
tb/tb_stereo.sv

//--- src/apb_cfg_regs.sv
`timescale 1ns/1ns

module apb_cfg_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  stereo_regs_pkg::apb_req_t apb,
    output logic [31:0]              rdata,
    output stereo_regs_pkg::cfg_t    cfg
);

    logic wr_en;

    assign wr_en = apb.sel && apb.enable && apb.write;  // access phase write

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cfg.range      <= stereo_regs_pkg::range_rst;
            cfg.threshold  <= stereo_regs_pkg::threshold_rst;
            cfg.clip_value <= stereo_regs_pkg::clip_rst;
        end else if (wr_en) begin
            case (apb.addr)
                stereo_regs_pkg::reg_range_addr: begin
                    cfg.range <= apb.wdata[3:0];
                end
                stereo_regs_pkg::reg_threshold_addr: begin
                    cfg.threshold <= apb.wdata[15:0];
                end
                stereo_regs_pkg::reg_clip_addr: begin
                    cfg.clip_value <= apb.wdata[15:0];
                end
                default: begin
                    // unmapped offset, nothing written
                end
            endcase
        end
    end

    // read mux follows addr directly
    always_comb begin
        case (apb.addr)
            stereo_regs_pkg::reg_range_addr: begin
                rdata = {28'd0, cfg.range};
            end
            stereo_regs_pkg::reg_threshold_addr: begin
                rdata = {16'd0, cfg.threshold};
            end
            stereo_regs_pkg::reg_clip_addr: begin
                rdata = {16'd0, cfg.clip_value};
            end
            default: begin
                rdata = 32'd0;
            end
        endcase
    end

endmodule

//--- src/disparity_select.sv
`timescale 1ns/1ns

module disparity_select (
    input  logic                                       clk,
    input  logic                                       rst,
    input  stereo_pkg::cost_t [stereo_pkg::num_disp-1:0] costs,
    input  logic                                       val,
    input  stereo_regs_pkg::cfg_t                      cfg,
    output stereo_pkg::disp_beat_t                     disp_out
);

    logic                             val_d;     // aligned with costs
    logic                             sel_val;
    stereo_pkg::disp_t                sel_disp;
    logic [stereo_pkg::disp_idx_w-1:0] best_idx;
    stereo_pkg::cost_t                best_cost;

    // winner take all, strict compare keeps the lowest index on ties
    always_comb begin
        best_idx  = '0;
        best_cost = '1;  // above any real 3-pixel sum
        for (int d = 0; d < stereo_pkg::num_disp; d++) begin
            // range above num_disp simply covers every candidate
            if (d < cfg.range && costs[d] < best_cost) begin
                best_cost = costs[d];
                best_idx  = d[stereo_pkg::disp_idx_w-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            val_d    <= 1'b0;
            sel_val  <= 1'b0;
            sel_disp <= '0;
            disp_out <= '0;
        end else begin
            val_d    <= val;
            sel_val  <= val_d;
            sel_disp <= {{(8-stereo_pkg::disp_idx_w){1'b0}}, best_idx, 8'h00};

            disp_out.val <= sel_val;
            if (sel_val && sel_disp < cfg.threshold) begin
                disp_out.disp <= cfg.clip_value;  // too close to trust
            end else begin
                disp_out.disp <= sel_disp;
            end
        end
    end

endmodule

//--- src/input_align.sv
`timescale 1ns/1ns

module input_align (
    input  logic                   clk,
    input  logic                   rst,
    input  stereo_pkg::stream_in_t stream_in,
    output stereo_pkg::aligned_t   aligned
);

    stereo_pkg::aligned_t stage1;
    logic                 v_end_dly;
    logic                 start_flag;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            v_end_dly  <= 1'b0;
            start_flag <= 1'b0;
            stage1     <= '0;
            aligned    <= '0;
        end else begin
            v_end_dly    <= stream_in.v_end;
            stage1.val   <= stream_in.hs;
            stage1.left  <= stream_in.left;
            stage1.right <= stream_in.right;

            // first frame end seen, stream may pass from now on
            if (v_end_dly && !stream_in.v_end) begin
                start_flag <= 1'b1;
            end

            if (start_flag) begin
                aligned <= stage1;
            end else begin
                aligned <= '0;  // held blank until start
            end
        end
    end

endmodule

//--- src/match_cost_unit.sv
`timescale 1ns/1ns

module match_cost_unit (
    input  logic               clk,
    input  logic               rst,
    input  stereo_pkg::pixel_t left,
    input  stereo_pkg::pixel_t right,
    output stereo_pkg::cost_t  cost
);

    stereo_pkg::pixel_t diff;
    stereo_pkg::pixel_t diff_d1;  // one pixel back
    stereo_pkg::pixel_t diff_d2;  // two pixels back

    always_comb begin
        if (left > right) begin
            diff = left - right;
        end else begin
            diff = right - left;
        end
    end

    // 3-wide horizontal window, no valid needed since blanking feeds zeros
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            diff_d1 <= '0;
            diff_d2 <= '0;
            cost    <= '0;
        end else begin
            diff_d1 <= diff;
            diff_d2 <= diff_d1;
            cost    <= stereo_pkg::cost_t'(diff)
                     + stereo_pkg::cost_t'(diff_d1)
                     + stereo_pkg::cost_t'(diff_d2);
        end
    end

endmodule

//--- src/right_delay_line.sv
`timescale 1ns/1ns

module right_delay_line (
    input  logic                 clk,
    input  logic                 rst,
    input  stereo_pkg::aligned_t aligned,
    output stereo_pkg::tap_bus_t taps
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            taps <= '0;
        end else begin
            taps.val <= aligned.val;

            if (aligned.val) begin
                taps.left     <= aligned.left;
                taps.right[0] <= aligned.right;
                // older pixels move one tap further out
                for (int d = 1; d < stereo_pkg::num_disp; d++) begin
                    taps.right[d] <= taps.right[d-1];
                end
            end else begin
                // blanking empties the chain for the next line
                taps.left  <= '0;
                taps.right <= '0;
            end
        end
    end

endmodule

//--- src/stereo_pkg.sv
package stereo_pkg;

    localparam int pix_w      = 8;
    localparam int num_disp   = 8;
    localparam int disp_idx_w = 3;   // log2 of num_disp
    localparam int cost_w     = 10;  // 3 * 255 fits

    typedef logic [pix_w-1:0]  pixel_t;
    typedef logic [15:0]       disp_t;   // 8.8 fixed point
    typedef logic [cost_w-1:0] cost_t;

    typedef struct packed {
        pixel_t left;
        pixel_t right;
        logic   hs;     // pixel valid level
        logic   v_end;  // frame end level
    } stream_in_t;

    typedef struct packed {
        logic   val;
        pixel_t left;
        pixel_t right;
    } aligned_t;

    typedef struct packed {
        logic                  val;
        pixel_t                left;
        pixel_t [num_disp-1:0] right;  // tap d is right pixel d positions back
    } tap_bus_t;

    typedef struct packed {
        logic  val;
        disp_t disp;
    } disp_beat_t;

endpackage

//--- src/stereo_regs_pkg.sv
package stereo_regs_pkg;

    typedef struct packed {
        logic        sel;
        logic        enable;
        logic        write;
        logic [11:0] addr;
        logic [31:0] wdata;
    } apb_req_t;

    // register map
    localparam logic [11:0] reg_range_addr     = 12'h000;
    localparam logic [11:0] reg_threshold_addr = 12'h004;
    localparam logic [11:0] reg_clip_addr      = 12'h008;

    localparam logic [3:0]  range_rst     = 4'd8;   // full search
    localparam logic [15:0] threshold_rst = 16'h0000;
    localparam logic [15:0] clip_rst      = 16'h0000;

    typedef struct packed {
        logic [3:0]  range;       // number of candidates searched
        logic [15:0] threshold;   // clip below this disparity
        logic [15:0] clip_value;
    } cfg_t;

endpackage

//--- src/stereo_top.sv
`timescale 1ns/1ns

module stereo_top (
    input  logic                      clk,
    input  logic                      rst,
    input  stereo_pkg::stream_in_t    stream_in,
    input  stereo_regs_pkg::apb_req_t apb,
    output logic [31:0]               apb_rdata,
    output stereo_pkg::disp_beat_t    disp_out
);

    stereo_pkg::aligned_t                          aligned;
    stereo_pkg::tap_bus_t                          taps;
    stereo_pkg::cost_t [stereo_pkg::num_disp-1:0]  costs;
    stereo_regs_pkg::cfg_t                         cfg;

    input_align u_input_align (
        .clk       (clk),
        .rst       (rst),
        .stream_in (stream_in),
        .aligned   (aligned)
    );

    right_delay_line u_right_delay_line (
        .clk     (clk),
        .rst     (rst),
        .aligned (aligned),
        .taps    (taps)
    );

    // one cost unit per candidate disparity
    for (genvar d = 0; d < stereo_pkg::num_disp; d++) begin : g_cost
        match_cost_unit u_match_cost_unit (
            .clk   (clk),
            .rst   (rst),
            .left  (taps.left),
            .right (taps.right[d]),
            .cost  (costs[d])
        );
    end

    disparity_select u_disparity_select (
        .clk      (clk),
        .rst      (rst),
        .costs    (costs),
        .val      (taps.val),
        .cfg      (cfg),
        .disp_out (disp_out)
    );

    apb_cfg_regs u_apb_cfg_regs (
        .clk   (clk),
        .rst   (rst),
        .apb   (apb),
        .rdata (apb_rdata),
        .cfg   (cfg)
    );

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // low for 10 cycles, released on a falling edge
    initial begin
        rst = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b1;
    end

endmodule

//--- tb/tb_stereo.sv
`timescale 1ns/1ns

module tb_stereo;

    localparam int line_len  = 24;
    localparam int blank_len = 4;
    localparam int latency   = 6;   // falling edges from drive to output

    logic                      clk;
    logic                      rst;
    stereo_pkg::stream_in_t    stream_in;
    stereo_regs_pkg::apb_req_t apb;
    logic [31:0]               apb_rdata;
    stereo_pkg::disp_beat_t    disp_out;

    int                 seed;
    int                 cyc;
    int                 checks;
    int                 errors;
    int                 beats_seen;
    int                 idx_limit;
    int                 due;
    stereo_pkg::disp_t  exp_disp;
    stereo_pkg::disp_t  exp_q[$];
    int                 due_q[$];
    stereo_pkg::pixel_t left_line [0:line_len-1];
    stereo_pkg::pixel_t right_line[0:line_len-1];
    logic [3:0]         cur_range;
    stereo_pkg::disp_t  cur_thr;
    stereo_pkg::disp_t  cur_clip;
    logic [31:0]        rd;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    stereo_top dut (
        .clk       (clk),
        .rst       (rst),
        .stream_in (stream_in),
        .apb       (apb),
        .apb_rdata (apb_rdata),
        .disp_out  (disp_out)
    );

    always @(posedge clk) cyc <= cyc + 1;  // read on falling edges only

    // expected disparity for pixel pos of the stored line
    function automatic stereo_pkg::disp_t ref_disp(input int pos, input logic [3:0] rng,
            input stereo_pkg::disp_t thr, input stereo_pkg::disp_t clp);
        int cost;
        int best_cost;
        int best_idx;
        int lp;
        int rp;
        stereo_pkg::disp_t d_val;
        best_cost = 1 << 30;
        best_idx  = 0;
        for (int d = 0; d < stereo_pkg::num_disp && d < rng; d++) begin
            cost = 0;
            for (int j = pos - 2; j <= pos; j++) begin
                lp = (j >= 0) ? int'(left_line[j]) : 0;          // zero before line start
                rp = (j - d >= 0) ? int'(right_line[j - d]) : 0;
                cost += (lp > rp) ? lp - rp : rp - lp;
            end
            if (cost < best_cost) begin  // lowest index wins ties
                best_cost = cost;
                best_idx  = d;
            end
        end
        d_val = {best_idx[7:0], 8'h00};
        if (d_val < thr) begin
            return clp;
        end
        return d_val;
    endfunction

    task automatic check_disp(input string name, input stereo_pkg::disp_t got,
            input stereo_pkg::disp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_rdata(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // beats are compared on the falling edge
    always @(negedge clk) begin
        if (rst && disp_out.val) begin
            beats_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("disp_out beat 0x%h arrived with no beat expected", disp_out.disp);
            end else begin
                exp_disp = exp_q.pop_front();
                due      = due_q.pop_front();
                check_disp("disp_out.disp", disp_out.disp, exp_disp);
                if (cyc != due) begin
                    errors++;
                    $display("beat arrived at cycle %0d instead of cycle %0d", cyc, due);
                end
                if (idx_limit < stereo_pkg::num_disp && disp_out.disp[15:8] >= idx_limit) begin
                    errors++;
                    $display("disparity 0x%h lies outside the configured range",
                             disp_out.disp);
                end
            end
        end
    end

    task automatic final_report();
        $display("checks %0d, errors %0d, beats %0d", checks, errors, beats_seen);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        final_report();
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        $display("test %0d %s finished with %0d errors", num, name, errors - err_start);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (!rst && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (!rst) abort_run("timeout: reset never released");
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) abort_run("timeout: expected disparity beats never arrived");
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(negedge clk);
        apb.sel    = 1'b1;
        apb.enable = 1'b0;
        apb.write  = 1'b1;
        apb.addr   = addr;
        apb.wdata  = data;
        @(negedge clk);
        apb.enable = 1'b1;  // access phase with the write on the next rising edge
        @(negedge clk);
        apb.sel    = 1'b0;
        apb.enable = 1'b0;
        apb.write  = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [11:0] addr,
            input logic [31:0] exp);
        @(negedge clk);
        apb.sel   = 1'b1;
        apb.write = 1'b0;
        apb.addr  = addr;
        @(negedge clk);
        apb.enable = 1'b1;
        @(negedge clk);
        rd         = apb_rdata;
        apb.sel    = 1'b0;
        apb.enable = 1'b0;
        check_rdata(name, rd, exp);
    endtask

    // right line is the left line moved by sh pixels
    task automatic drive_line(input int sh, input bit expect_out);
        stereo_pkg::pixel_t base[0:line_len+stereo_pkg::num_disp-1];
        for (int i = 0; i < line_len + stereo_pkg::num_disp; i++) begin
            base[i] = $random(seed);
        end
        for (int i = 0; i < line_len; i++) begin
            left_line[i]  = base[i];
            right_line[i] = base[i + sh];
        end
        for (int i = 0; i < line_len; i++) begin
            @(negedge clk);
            stream_in.hs    = 1'b1;
            stream_in.left  = left_line[i];
            stream_in.right = right_line[i];
            if (expect_out) begin
                exp_q.push_back(ref_disp(i, cur_range, cur_thr, cur_clip));
                due_q.push_back(cyc + latency);
            end
        end
        for (int i = 0; i < blank_len; i++) begin
            @(negedge clk);
            stream_in.hs    = 1'b0;
            stream_in.left  = '0;
            stream_in.right = '0;
        end
    endtask

    task automatic run_line(input int sh);
        int b;
        b = beats_seen;
        drive_line(sh, 1'b1);
        wait_drain();
        repeat (blank_len) @(negedge clk);
        if (beats_seen - b != line_len) begin
            errors++;
            $display("line gave %0d beats instead of %0d", beats_seen - b, line_len);
        end
    endtask

    initial begin
        int e;
        int b;
        int n;
        stream_in  = '0;
        apb        = '0;
        seed       = 91;
        cyc        = 0;
        checks     = 0;
        errors     = 0;
        beats_seen = 0;
        idx_limit  = 8;
        cur_range  = stereo_regs_pkg::range_rst;
        cur_thr    = stereo_regs_pkg::threshold_rst;
        cur_clip   = stereo_regs_pkg::clip_rst;
        wait_reset_release();

        e = errors;
        @(negedge clk);
        if (disp_out.val !== 1'b0) begin
            errors++;
            $display("disp_out.val is high right after reset");
        end
        check_disp("disp_out.disp", disp_out.disp, '0);
        check_rdata("apb_rdata", apb_rdata, 32'd8);  // addr 0 shows range
        read_check("range", stereo_regs_pkg::reg_range_addr, 32'd8);
        read_check("threshold", stereo_regs_pkg::reg_threshold_addr, 32'd0);
        read_check("clip_value", stereo_regs_pkg::reg_clip_addr, 32'd0);
        report_test(1, "reset values", e);

        e = errors;
        b = beats_seen;
        drive_line(2, 1'b0);
        n = 0;
        while (beats_seen == b && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (beats_seen != b) begin
            errors++;
            $display("output beat seen before the stream was opened");
        end
        report_test(2, "gated stream", e);

        // falling edge of v_end opens the stream
        @(negedge clk);
        stream_in.v_end = 1'b1;
        repeat (2) @(negedge clk);
        stream_in.v_end = 1'b0;
        repeat (3) @(negedge clk);

        e = errors;
        for (int k = 0; k < 4; k++) begin
            run_line({$random(seed)} % stereo_pkg::num_disp);
        end
        report_test(3, "random lines", e);

        e = errors;
        apb_write(stereo_regs_pkg::reg_range_addr, 32'd3);
        cur_range = 4'd3;
        idx_limit = 3;
        for (int k = 0; k < 3; k++) begin
            run_line({$random(seed)} % stereo_pkg::num_disp);
        end
        idx_limit = 8;
        apb_write(stereo_regs_pkg::reg_range_addr, 32'd8);
        cur_range = 4'd8;
        report_test(4, "range limit", e);

        e = errors;
        apb_write(stereo_regs_pkg::reg_threshold_addr, 32'h0000_0400);
        apb_write(stereo_regs_pkg::reg_clip_addr, 32'h0000_abcd);
        cur_thr  = 16'h0400;
        cur_clip = 16'habcd;
        for (int k = 0; k < 3; k++) begin
            run_line({$random(seed)} % stereo_pkg::num_disp);
        end
        report_test(5, "clip stage", e);

        e = errors;
        apb_write(12'h00c, 32'hffff_ffff);
        apb_write(12'h010, 32'h8765_4321);
        read_check("range", stereo_regs_pkg::reg_range_addr, 32'd8);
        read_check("threshold", stereo_regs_pkg::reg_threshold_addr, 32'h0400);
        read_check("clip_value", stereo_regs_pkg::reg_clip_addr, 32'habcd);
        read_check("unmapped 0x00c", 12'h00c, 32'd0);
        apb_write(stereo_regs_pkg::reg_range_addr, 32'hffff_ffff);
        apb_write(stereo_regs_pkg::reg_threshold_addr, 32'h1234_5678);
        apb_write(stereo_regs_pkg::reg_clip_addr, 32'hdead_beef);
        read_check("range", stereo_regs_pkg::reg_range_addr, 32'h0000_000f);
        read_check("threshold", stereo_regs_pkg::reg_threshold_addr, 32'h0000_5678);
        read_check("clip_value", stereo_regs_pkg::reg_clip_addr, 32'h0000_beef);
        report_test(6, "register access", e);

        final_report();
    end

endmodule
